// ==== verilog/freq_meter_pkg.sv ====
/*
 * shared widths, AXI4-Lite register map and response codes
 * measurement record type carried from timer to bus
 */
`default_nettype none

package freq_meter_pkg;

    // timestamp and totals
    localparam int tick_w = 32;        // ~21 s of wrap at 200 MHz
    localparam int ncyc_w = 16;        // periods per record

    // record buffer
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);   // holds 0..depth

    // bus widths
    localparam int axil_addr_w = 5;
    localparam int axil_data_w = 32;

    // register offsets
    localparam logic [axil_addr_w-1:0] reg_ctrl   = 5'h00;  // bit 0 enable
    localparam logic [axil_addr_w-1:0] reg_ncyc   = 5'h04;  // N, resets to 1
    localparam logic [axil_addr_w-1:0] reg_status = 5'h08;  // {overrun, empty}
    localparam logic [axil_addr_w-1:0] reg_high   = 5'h0C;  // head high_ticks
    localparam logic [axil_addr_w-1:0] reg_period = 5'h10;  // head period, pops

    localparam logic [1:0] axil_resp_okay   = 2'b00;
    localparam logic [1:0] axil_resp_slverr = 2'b10;

    // one finished measurement window of N periods
    typedef struct packed {
        logic [tick_w-1:0] period_ticks;  // closing minus opening timestamp
        logic [tick_w-1:0] high_ticks;    // cycles with wave high
    } meas_rec_t;

endpackage

`default_nettype wire

// ==== verilog/meas_if.sv ====
/*
 * valid/ready record channel
 * source drives valid and rec, sink drives ready
 */
`timescale 1ns/1ps
`default_nettype none

interface meas_if;

    logic                      valid;  // rec is meaningful
    logic                      ready;  // sink can take it this cycle
    freq_meter_pkg::meas_rec_t rec;    // held stable until accepted

    // producer side
    modport source (
        output valid,
        output rec,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  rec,
        output ready
    );

endinterface

`default_nettype wire

// ==== verilog/edge_timer.sv ====
/*
 * wave_in synchronizer and rising edge detect
 * free running timestamp, N period window, record output with overrun flag
 */
`timescale 1ns/1ps
`default_nettype none

module edge_timer (
    input  logic                              pll_clk,
    input  logic                              sys_rst_n,
    input  logic                              wave_in,      // async square wave
    input  logic                              enable,
    input  logic [freq_meter_pkg::ncyc_w-1:0] ncyc,         // periods per record
    input  logic                              overrun_clr,  // one cycle pulse
    output logic                              overrun,
    meas_if.source                            rec_out
);

    logic                              wave_s1;
    logic                              wave_s2;     // synchronized level
    logic                              wave_d;      // edge flop
    logic                              edge_stb;
    logic [freq_meter_pkg::tick_w-1:0] ts_cnt;
    logic [freq_meter_pkg::tick_w-1:0] start_ts;
    logic [freq_meter_pkg::tick_w-1:0] high_acc;
    logic [freq_meter_pkg::ncyc_w-1:0] edge_cnt;    // edges seen in window
    logic                              armed;       // start timestamp taken
    logic                              last_edge;
    logic                              close_win;
    logic                              drop;
    logic                              valid_q;
    freq_meter_pkg::meas_rec_t         rec_q;

    // two flop sync plus one for edge detect
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wave_s1 <= 1'b0;
            wave_s2 <= 1'b0;
            wave_d  <= 1'b0;
        end else begin
            wave_s1 <= wave_in;
            wave_s2 <= wave_s1;
            wave_d  <= wave_s2;
        end
    end

    assign edge_stb = wave_s2 & ~wave_d;  // rising edge, 3 cycles after wave_in

    // free running timestamp, wraps
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) ts_cnt <= '0;
        else            ts_cnt <= ts_cnt + 1'b1;
    end

    // N of 0 behaves as 1
    assign last_edge = ({1'b0, edge_cnt} + 1'b1) >= {1'b0, ncyc};
    assign close_win = enable && armed && edge_stb && last_edge;
    assign drop      = close_win && valid_q && !rec_out.ready;  // old record still waiting

    // window control
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            armed    <= 1'b0;
            edge_cnt <= '0;
        end else if (!enable) begin  // abandon window
            armed    <= 1'b0;
            edge_cnt <= '0;
        end else if (edge_stb) begin
            armed    <= 1'b1;
            edge_cnt <= (armed && !last_edge) ? edge_cnt + 1'b1 : '0;
        end
    end

    // window start and high time, restarted on the closing edge too
    always_ff @(posedge pll_clk) begin
        if (edge_stb && (!armed || last_edge)) begin
            start_ts <= ts_cnt;
            high_acc <= freq_meter_pkg::tick_w'(1);  // strobe cycle is high
        end else if (wave_s2) begin
            high_acc <= high_acc + 1'b1;
        end
    end

    // record handshake and sticky overrun
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            valid_q <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (close_win && !drop) valid_q <= 1'b1;
            else if (rec_out.ready) valid_q <= 1'b0;  // accepted
            if (drop)             overrun <= 1'b1;    // set wins over clear
            else if (overrun_clr) overrun <= 1'b0;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (close_win && !drop) begin
            rec_q.period_ticks <= ts_cnt - start_ts;  // modulo 2^32
            rec_q.high_ticks   <= high_acc;
        end
    end

    assign rec_out.valid = valid_q;
    assign rec_out.rec   = rec_q;

endmodule

`default_nettype wire

// ==== verilog/meas_fifo.sv ====
/*
 * synchronous circular FIFO for measurement records
 * payload type is a parameter, depth comes from the package
 */
`timescale 1ns/1ps
`default_nettype none

module meas_fifo #(
    parameter type payload_t = freq_meter_pkg::meas_rec_t
) (
    input  logic   pll_clk,
    input  logic   sys_rst_n,
    meas_if.sink   wr,        // from edge_timer
    meas_if.source rd,        // to register block
    output logic   empty
);

    payload_t                              mem [freq_meter_pkg::fifo_depth];
    logic     [freq_meter_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic     [freq_meter_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic     [freq_meter_pkg::fifo_cnt_w-1:0] count;   // occupancy
    logic                                      push;
    logic                                      pop;
    logic                                      full;

    assign full  = count == freq_meter_pkg::fifo_cnt_w'(freq_meter_pkg::fifo_depth);
    assign empty = count == '0;
    assign push  = wr.valid && wr.ready;
    assign pop   = rd.valid && rd.ready;

    assign wr.ready = !full;        // back-pressure
    assign rd.valid = !empty;
    assign rd.rec   = mem[rd_ptr];  // head entry

    // storage, no reset
    always_ff @(posedge pll_clk) begin
        if (push) mem[wr_ptr] <= wr.rec;
    end

    // pointers wrap at depth
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == freq_meter_pkg::fifo_ptr_w'(freq_meter_pkg::fifo_depth - 1))
                          ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == freq_meter_pkg::fifo_ptr_w'(freq_meter_pkg::fifo_depth - 1))
                          ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axil_meas_regs.sv ====
/*
 * AXI4-Lite slave for the frequency meter
 * control and N registers, status, head record read with pop on period
 */
`timescale 1ns/1ps
`default_nettype none

module axil_meas_regs (
    input  logic                                   pll_clk,
    input  logic                                   sys_rst_n,
    input  logic [freq_meter_pkg::axil_addr_w-1:0] awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  logic [freq_meter_pkg::axil_data_w-1:0] wdata,
    input  logic [freq_meter_pkg::axil_data_w/8-1:0] wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  logic [freq_meter_pkg::axil_addr_w-1:0] araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output logic [freq_meter_pkg::axil_data_w-1:0] rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready,
    meas_if.sink                                   rec_in,      // FIFO head
    input  logic                                   fifo_empty,
    input  logic                                   overrun,
    output logic                                   enable,
    output logic [freq_meter_pkg::ncyc_w-1:0]      ncyc,
    output logic                                   overrun_clr
);

    logic                                   wr_hs;
    logic                                   rd_hs;
    logic [freq_meter_pkg::axil_data_w-1:0] rd_mux;
    logic [1:0]                             rd_resp;

    assign wr_hs = awvalid && awready && wvalid && wready;
    assign rd_hs = arvalid && arready;
    assign bresp = freq_meter_pkg::axil_resp_okay;  // writes always succeed

    // write channel, aw and w accepted together
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            enable      <= 1'b0;
            ncyc        <= freq_meter_pkg::ncyc_w'(1);
            overrun_clr <= 1'b0;
        end else begin
            overrun_clr <= 1'b0;  // pulse
            if (wr_hs) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= 1'b1;
                case (awaddr)
                    freq_meter_pkg::reg_ctrl: begin
                        if (wstrb[0]) enable <= wdata[0];
                        overrun_clr <= 1'b1;  // any ctrl write
                    end
                    freq_meter_pkg::reg_ncyc: begin
                        for (int b = 0; b < freq_meter_pkg::ncyc_w / 8; b++) begin
                            if (wstrb[b]) ncyc[b*8 +: 8] <= wdata[b*8 +: 8];
                        end
                    end
                    default: ;  // read only or unmapped
                endcase
            end else if (awvalid && wvalid && !bvalid && !awready) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

    // read mux
    always_comb begin
        rd_mux  = '0;
        rd_resp = freq_meter_pkg::axil_resp_okay;
        case (araddr)
            freq_meter_pkg::reg_ctrl:   rd_mux[0] = enable;
            freq_meter_pkg::reg_ncyc:   rd_mux[freq_meter_pkg::ncyc_w-1:0] = ncyc;
            freq_meter_pkg::reg_status: rd_mux[1:0] = {overrun, fifo_empty};
            freq_meter_pkg::reg_high: begin
                if (rec_in.valid) rd_mux = rec_in.rec.high_ticks;
            end
            freq_meter_pkg::reg_period: begin
                if (rec_in.valid) rd_mux  = rec_in.rec.period_ticks;
                else              rd_resp = freq_meter_pkg::axil_resp_slverr;  // nothing queued
            end
            default: rd_resp = freq_meter_pkg::axil_resp_slverr;
        endcase
    end

    // pop as the period word is latched
    assign rec_in.ready = rd_hs && (araddr == freq_meter_pkg::reg_period) && rec_in.valid;

    // read channel, arready tracks !rvalid
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_hs) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge pll_clk) begin
        if (rd_hs) begin
            rdata <= rd_mux;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/freq_meter_top.sv ====
/*
 * frequency and duty meter top level
 * edge timer, record FIFO and AXI4-Lite registers on pll_clk
 */
`timescale 1ns/1ps
`default_nettype none

module freq_meter_top (
    input  logic                                     pll_clk,
    input  logic                                     sys_rst_n,
    input  logic                                     wave_in,        // async
    input  logic [freq_meter_pkg::axil_addr_w-1:0]   s_axil_awaddr,
    input  logic                                     s_axil_awvalid,
    output logic                                     s_axil_awready,
    input  logic [freq_meter_pkg::axil_data_w-1:0]   s_axil_wdata,
    input  logic [freq_meter_pkg::axil_data_w/8-1:0] s_axil_wstrb,
    input  logic                                     s_axil_wvalid,
    output logic                                     s_axil_wready,
    output logic [1:0]                               s_axil_bresp,
    output logic                                     s_axil_bvalid,
    input  logic                                     s_axil_bready,
    input  logic [freq_meter_pkg::axil_addr_w-1:0]   s_axil_araddr,
    input  logic                                     s_axil_arvalid,
    output logic                                     s_axil_arready,
    output logic [freq_meter_pkg::axil_data_w-1:0]   s_axil_rdata,
    output logic [1:0]                               s_axil_rresp,
    output logic                                     s_axil_rvalid,
    input  logic                                     s_axil_rready
);

    logic                              enable;
    logic [freq_meter_pkg::ncyc_w-1:0] ncyc;
    logic                              overrun_clr;
    logic                              overrun;
    logic                              fifo_empty;

    meas_if tmr_if ();  // timer to FIFO
    meas_if rd_if ();   // FIFO head to bus

    edge_timer u_edge_timer (
        .pll_clk     (pll_clk),
        .sys_rst_n   (sys_rst_n),
        .wave_in     (wave_in),
        .enable      (enable),
        .ncyc        (ncyc),
        .overrun_clr (overrun_clr),
        .overrun     (overrun),
        .rec_out     (tmr_if.source)
    );

    meas_fifo #(
        .payload_t (freq_meter_pkg::meas_rec_t)
    ) u_meas_fifo (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .wr        (tmr_if.sink),
        .rd        (rd_if.source),
        .empty     (fifo_empty)
    );

    axil_meas_regs u_axil_meas_regs (
        .pll_clk     (pll_clk),
        .sys_rst_n   (sys_rst_n),
        .awaddr      (s_axil_awaddr),
        .awvalid     (s_axil_awvalid),
        .awready     (s_axil_awready),
        .wdata       (s_axil_wdata),
        .wstrb       (s_axil_wstrb),
        .wvalid      (s_axil_wvalid),
        .wready      (s_axil_wready),
        .bresp       (s_axil_bresp),
        .bvalid      (s_axil_bvalid),
        .bready      (s_axil_bready),
        .araddr      (s_axil_araddr),
        .arvalid     (s_axil_arvalid),
        .arready     (s_axil_arready),
        .rdata       (s_axil_rdata),
        .rresp       (s_axil_rresp),
        .rvalid      (s_axil_rvalid),
        .rready      (s_axil_rready),
        .rec_in      (rd_if.sink),
        .fifo_empty  (fifo_empty),
        .overrun     (overrun),
        .enable      (enable),
        .ncyc        (ncyc),
        .overrun_clr (overrun_clr)
    );

endmodule

`default_nettype wire

// ==== dv/freq_meter_asserts.sv ====
/*
 * bound concurrent checks for freq_meter_top
 * AXI4-Lite valid hold and response ordering, record FIFO fill limit
 */
`timescale 1ns/1ps
`default_nettype none

module freq_meter_asserts (
    input logic pll_clk,
    input logic sys_rst_n,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic arvalid,
    input logic arready,
    input logic rvalid,
    input logic rready,
    input logic push_valid,   // timer to FIFO
    input logic push_ready,
    input logic pop_valid,    // FIFO to bus
    input logic pop_ready
);

    int fill;      // occupancy model
    int fail_cnt;  // failures seen so far

    initial fail_cnt = 0;

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) fill <= 0;
        else fill <= fill + int'(push_valid && push_ready) - int'(pop_valid && pop_ready);
    end

    // valids hold until taken
    aw_hold: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        awvalid && !awready |=> awvalid)
        else begin $error("awvalid dropped before awready"); fail_cnt++; end
    w_hold: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        wvalid && !wready |=> wvalid)
        else begin $error("wvalid dropped before wready"); fail_cnt++; end
    ar_hold: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        arvalid && !arready |=> arvalid)
        else begin $error("arvalid dropped before arready"); fail_cnt++; end
    b_hold: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        bvalid && !bready |=> bvalid)
        else begin $error("bvalid dropped before bready"); fail_cnt++; end
    r_hold: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        rvalid && !rready |=> rvalid)
        else begin $error("rvalid dropped before rready"); fail_cnt++; end

    // responses only after their request
    b_after_aw: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready))
        else begin $error("bvalid without write handshake"); fail_cnt++; end
    r_after_ar: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        $rose(rvalid) |-> $past(arvalid && arready))
        else begin $error("rvalid without read handshake"); fail_cnt++; end

    no_push_full: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        push_valid && push_ready |-> fill < freq_meter_pkg::fifo_depth)
        else begin $error("FIFO accepted a record while full"); fail_cnt++; end

endmodule

bind freq_meter_top freq_meter_asserts u_freq_meter_asserts (
    .pll_clk    (pll_clk),
    .sys_rst_n  (sys_rst_n),
    .awvalid    (s_axil_awvalid),
    .awready    (s_axil_awready),
    .wvalid     (s_axil_wvalid),
    .wready     (s_axil_wready),
    .bvalid     (s_axil_bvalid),
    .bready     (s_axil_bready),
    .arvalid    (s_axil_arvalid),
    .arready    (s_axil_arready),
    .rvalid     (s_axil_rvalid),
    .rready     (s_axil_rready),
    .push_valid (tmr_if.valid),
    .push_ready (tmr_if.ready),
    .pop_valid  (rd_if.valid),
    .pop_ready  (rd_if.ready)
);

`default_nettype wire

// ==== dv/tb_freq_meter.sv ====
/*
 * testbench for freq_meter_top
 * clock, reset, LCG, AXI4-Lite bus tasks, square wave source, record checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_freq_meter;

    localparam int bus_tmo = 200;  // cycles per bus phase

    logic                                     pll_clk;
    logic                                     sys_rst_n;
    logic                                     wave_in;
    logic [freq_meter_pkg::axil_addr_w-1:0]   awaddr;
    logic                                     awvalid;
    logic                                     awready;
    logic [freq_meter_pkg::axil_data_w-1:0]   wdata;
    logic [freq_meter_pkg::axil_data_w/8-1:0] wstrb;
    logic                                     wvalid;
    logic                                     wready;
    logic [1:0]                               bresp;
    logic                                     bvalid;
    logic                                     bready;
    logic [freq_meter_pkg::axil_addr_w-1:0]   araddr;
    logic                                     arvalid;
    logic                                     arready;
    logic [freq_meter_pkg::axil_data_w-1:0]   rdata;
    logic [1:0]                               rresp;
    logic                                     rvalid;
    logic                                     rready;

    int          err_cnt;
    int          chk_cnt;
    logic [31:0] lcg_state;
    logic        wave_on;   // generator run
    int          wave_h;    // high cycles
    int          wave_l;    // low cycles
    int          wave_ph;
    int          cur_h;     // expected values for the current run
    int          cur_l;
    int          cur_n;

    freq_meter_top u_freq_meter_top (
        .pll_clk        (pll_clk),
        .sys_rst_n      (sys_rst_n),
        .wave_in        (wave_in),
        .s_axil_awaddr  (awaddr),
        .s_axil_awvalid (awvalid),
        .s_axil_awready (awready),
        .s_axil_wdata   (wdata),
        .s_axil_wstrb   (wstrb),
        .s_axil_wvalid  (wvalid),
        .s_axil_wready  (wready),
        .s_axil_bresp   (bresp),
        .s_axil_bvalid  (bvalid),
        .s_axil_bready  (bready),
        .s_axil_araddr  (araddr),
        .s_axil_arvalid (arvalid),
        .s_axil_arready (arready),
        .s_axil_rdata   (rdata),
        .s_axil_rresp   (rresp),
        .s_axil_rvalid  (rvalid),
        .s_axil_rready  (rready)
    );

    initial begin
        pll_clk = 1'b0;
        forever #10 pll_clk = ~pll_clk;  // 50 MHz
    end

    // square wave, H cycles high then L low, restarts high when switched on
    initial begin
        wave_in = 1'b0;
        wave_ph = 0;
        forever begin
            @(posedge pll_clk);
            if (!wave_on) begin
                wave_ph = 0;
                wave_in <= 1'b0;
            end else begin
                wave_in <= (wave_ph < wave_h);
                wave_ph = (wave_ph + 1 == wave_h + wave_l) ? 0 : wave_ph + 1;
            end
        end
    end

    // LCG, value in lo..hi
    function automatic int rand_range(input int lo, input int hi);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lo + int'((lcg_state >> 8) % (hi - lo + 1));
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp)
        else begin
            err_cnt++;
            $display("ERROR at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        err_cnt++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int n;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        n = 0;
        do begin
            @(posedge pll_clk);
            n++;
        end while (!(awready && wready) && n < bus_tmo);
        if (!(awready && wready)) note_timeout("awready/wready");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (rand_range(0, 3)) @(posedge pll_clk);  // slow master
        bready <= 1'b1;
        n = 0;
        do begin
            @(posedge pll_clk);
            n++;
        end while (!bvalid && n < bus_tmo);
        if (!bvalid) note_timeout("bvalid");
        bready <= 1'b0;
        check_value("bresp", 32'(bresp), 32'(freq_meter_pkg::axil_resp_okay));
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        do begin
            @(posedge pll_clk);
            n++;
        end while (!arready && n < bus_tmo);
        if (!arready) note_timeout("arready");
        arvalid <= 1'b0;
        repeat (rand_range(0, 3)) @(posedge pll_clk);
        rready <= 1'b1;
        n = 0;
        do begin
            @(posedge pll_clk);
            n++;
        end while (!rvalid && n < bus_tmo);
        if (!rvalid) note_timeout("rvalid");
        rready <= 1'b0;
        data = rdata;  // pre-edge value, stable
        resp = rresp;
    endtask

    task automatic check_status(input logic [31:0] exp);
        logic [31:0] d;
        logic [1:0]  rsp;
        axil_read(freq_meter_pkg::reg_status, d, rsp);
        check_value("status", d, exp);
    endtask

    // head record against N*H and N*(H+L)
    task automatic check_record();
        logic [31:0] d;
        logic [1:0]  rsp;
        axil_read(freq_meter_pkg::reg_high, d, rsp);
        check_value("high_ticks", d, 32'(cur_n * cur_h));
        axil_read(freq_meter_pkg::reg_period, d, rsp);
        check_value("period_ticks", d, 32'(cur_n * (cur_h + cur_l)));
        check_value("rresp", 32'(rsp), 32'(freq_meter_pkg::axil_resp_okay));
    endtask

    // pop until empty, record in edge_timer follows into the FIFO
    task automatic drain_fifo();
        logic [31:0] st;
        logic [31:0] d;
        logic [1:0]  rsp;
        int          guard;
        guard = 0;
        repeat (4) @(posedge pll_clk);
        axil_read(freq_meter_pkg::reg_status, st, rsp);
        while (!st[0] && guard < 2 * freq_meter_pkg::fifo_depth + 4) begin
            axil_read(freq_meter_pkg::reg_period, d, rsp);
            axil_read(freq_meter_pkg::reg_status, st, rsp);
            guard++;
        end
        if (!st[0]) note_timeout("FIFO to drain");
    endtask

    task automatic wait_record(input int max_cyc);
        logic [31:0] st;
        logic [1:0]  rsp;
        int          waited;
        waited = 0;
        axil_read(freq_meter_pkg::reg_status, st, rsp);
        while (st[0] && waited < max_cyc) begin
            repeat (4) @(posedge pll_clk);
            waited += 4;
            axil_read(freq_meter_pkg::reg_status, st, rsp);
        end
        if (st[0]) note_timeout("a record");
    endtask

    // stop, flush, pick new H/L/N, restart
    task automatic start_measure(input int n);
        wave_on <= 1'b0;
        axil_write(freq_meter_pkg::reg_ctrl, 32'h0, 4'h1);  // disable, clears overrun
        drain_fifo();
        cur_n = n;
        cur_h = rand_range(3, 40);
        cur_l = rand_range(3, 40);
        wave_h <= cur_h;
        wave_l <= cur_l;
        axil_write(freq_meter_pkg::reg_ncyc, 32'(n), 4'hF);
        axil_write(freq_meter_pkg::reg_ctrl, 32'h1, 4'h1);
        wave_on <= 1'b1;
    endtask

    task automatic measure_run(input int n, input int recs);
        start_measure(n);
        repeat (recs) begin
            wait_record(4 * cur_n * (cur_h + cur_l) + 100);
            check_record();
            repeat (rand_range(0, 150)) @(posedge pll_clk);  // uneven gaps
        end
    endtask

    initial begin
        logic [31:0] d;
        logic [1:0]  rsp;
        int          n_recs;
        int          a_fail;
        sys_rst_n = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        err_cnt   = 0;
        chk_cnt   = 0;
        lcg_state = 32'h22a8_d516;
        wave_on   = 1'b0;
        wave_h    = 4;
        wave_l    = 4;
        repeat (16) @(posedge pll_clk);
        sys_rst_n <= 1'b1;
        repeat (4) @(posedge pll_clk);

        // reset values and ncyc readback with byte strobes
        axil_read(freq_meter_pkg::reg_ncyc, d, rsp);
        check_value("ncyc", d, 32'h1);
        check_status(32'h1);
        axil_write(freq_meter_pkg::reg_ncyc, 32'h0000_1234, 4'hF);
        axil_read(freq_meter_pkg::reg_ncyc, d, rsp);
        check_value("ncyc", d, 32'h0000_1234);
        axil_write(freq_meter_pkg::reg_ncyc, 32'h0000_ab99, 4'b0010);  // upper byte only
        axil_read(freq_meter_pkg::reg_ncyc, d, rsp);
        check_value("ncyc", d, 32'h0000_ab34);

        // pop of an empty FIFO
        axil_read(freq_meter_pkg::reg_period, d, rsp);
        check_value("rdata", d, 32'h0);
        check_value("rresp", 32'(rsp), 32'(freq_meter_pkg::axil_resp_slverr));
        check_status(32'h1);

        measure_run(1, 3);
        measure_run(5, 4);

        // overrun, bus idle while windows keep closing
        start_measure(2);
        repeat ((freq_meter_pkg::fifo_depth + 4) * cur_n * (cur_h + cur_l)) @(posedge pll_clk);
        wave_on <= 1'b0;
        repeat (8) @(posedge pll_clk);
        axil_read(freq_meter_pkg::reg_status, d, rsp);
        check_value("status", d, 32'h2);
        n_recs = 0;
        while (!d[0] && n_recs < freq_meter_pkg::fifo_depth + 4) begin
            check_record();
            n_recs++;
            axil_read(freq_meter_pkg::reg_status, d, rsp);
        end
        check_value("record count", 32'(n_recs), 32'(freq_meter_pkg::fifo_depth + 1));
        axil_write(freq_meter_pkg::reg_ctrl, 32'h0, 4'h1);
        check_status(32'h1);

        // disable stops records
        measure_run(3, 1);
        axil_write(freq_meter_pkg::reg_ctrl, 32'h0, 4'h1);
        drain_fifo();
        repeat (3 * cur_n * (cur_h + cur_l)) @(posedge pll_clk);
        check_status(32'h1);
        wave_on <= 1'b0;

        repeat (4) @(posedge pll_clk);
        a_fail = u_freq_meter_top.u_freq_meter_asserts.fail_cnt;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 chk_cnt, err_cnt, a_fail);
        if (err_cnt == 0 && a_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/freq_meter_pkg.sv
verilog/meas_if.sv
verilog/edge_timer.sv
verilog/meas_fifo.sv
verilog/axil_meas_regs.sv
verilog/freq_meter_top.sv
dv/freq_meter_asserts.sv
dv/tb_freq_meter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_freq_meter
FLAGS     ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
OBJ_DIR   ?= obj_dir

SRCS := $(filter-out +%,$(shell cat project.f))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) project.f Makefile
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
